//--- include/phy_csr_cfg.svh
// phy csr configuration macros for bus widths, reported version, drive strength and sync depth
`ifndef PHY_CSR_CFG_SVH
`define PHY_CSR_CFG_SVH

// width of the csr word address
`define PHY_CSR_ADDR_WIDTH 8

// width of the csr data bus, one byte enable per byte lane
`define PHY_CSR_DATA_WIDTH 32
`define PHY_CSR_BE_WIDTH 4

// ip version reported in the upper half of the VERSION register
`define PHY_CSR_IP_VERSION 16'd211

// drive strength field of mode register 3 as reported at MR3
`define PHY_CSR_MR3_DS 4'h0

// number of flops used to bring pll lock into the csr clock domain
`define PHY_CSR_SYNC_STAGES 2

`endif

//--- source/phy_csr_pkg.sv
// phy csr package holding the bus request and response, calibration and address types
`default_nettype none

package phy_csr_pkg;

	`include "phy_csr_cfg.svh"

	// one csr bus request as driven by the master in a single cycle
	typedef struct packed {
		logic [`PHY_CSR_ADDR_WIDTH-1:0] addr;
		logic [`PHY_CSR_BE_WIDTH-1:0]   be;
		logic [`PHY_CSR_DATA_WIDTH-1:0] wdata;
		logic                           write;
		logic                           read;
	} csr_req_t;

	// the csr response, read data is only meaningful while rdata_valid is high
	typedef struct packed {
		logic [`PHY_CSR_DATA_WIDTH-1:0] rdata;
		logic                           rdata_valid;
		logic                           waitrequest;
	} csr_rsp_t;

	// result of one calibration step, out selects write leveling over read capture
	typedef struct packed {
		logic [7:0] stage;
		logic [7:0] substage;
		logic [7:0] group;
		logic       pass;
		logic       out;
	} cal_step_t;

	// running calibration record with figures of merit and the first failure
	typedef struct packed {
		logic       success;
		logic       fail;
		logic [7:0] fom_in;
		logic [7:0] fom_out;
		logic [7:0] fail_stage;
		logic [7:0] fail_substage;
		logic [7:0] fail_group;
	} cal_status_t;

	// word addresses of the mapped registers, all others read back as zero
	typedef enum logic [`PHY_CSR_ADDR_WIDTH-1:0] {
		SIGNATURE = `PHY_CSR_ADDR_WIDTH'(1),
		VERSION   = `PHY_CSR_ADDR_WIDTH'(2),
		STATUS    = `PHY_CSR_ADDR_WIDTH'(4),
		FOM       = `PHY_CSR_ADDR_WIDTH'(5),
		FAIL_INFO = `PHY_CSR_ADDR_WIDTH'(6),
		SCRATCH   = `PHY_CSR_ADDR_WIDTH'(7),
		MR3       = `PHY_CSR_ADDR_WIDTH'(8)
	} csr_reg_addr_e;

endpackage

`default_nettype wire

//--- source/cal_result_tracker.sv
// calibration result tracker that folds per-step results into one status record
`default_nettype none

module cal_result_tracker
	import phy_csr_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  logic        cal_start,
	input  logic        cal_end,
	input  logic        step_valid,
	input  cal_step_t   step,
	output cal_status_t cal_status
);

	// registered record and its next value
	cal_status_t status_q;
	cal_status_t status_d;

	// add one to a figure of merit and hold it once it reaches the top
	function automatic logic [7:0] sat_inc(input logic [7:0] value);
		logic [7:0] result;
		if (value == 8'hff) begin
			result = value;
		end else begin
			result = value + 8'd1;
		end
		return result;
	endfunction

	// next state of the record
	// the step is folded in first so that cal_end sees a failure arriving on the same edge
	always_comb begin
		status_d = status_q;

		if (step_valid) begin
			if (step.pass) begin
				// passing steps only count toward their own direction
				if (step.out) begin
					status_d.fom_out = sat_inc(status_q.fom_out);
				end else begin
					status_d.fom_in = sat_inc(status_q.fom_in);
				end
			end else if (!status_q.fail) begin
				// only the first failure is kept, later ones leave the coordinates alone
				status_d.fail          = 1'b1;
				status_d.fail_stage    = step.stage;
				status_d.fail_substage = step.substage;
				status_d.fail_group    = step.group;
			end
		end

		// success is only ever granted at the end of a run without any failure
		if (cal_end && !status_d.fail) begin
			status_d.success = 1'b1;
		end

		// a new run clears everything, even a step or end strobe on the same edge
		if (cal_start) begin
			status_d = '0;
		end
	end

	// the record is control state for the csr block, so it is cleared by reset
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			status_q <= '0;
		end else begin
			status_q <= status_d;
		end
	end

	// the record goes straight out, the csr block does its own snapshot
	assign cal_status = status_q;

endmodule

`default_nettype wire

//--- source/phy_csr.sv
// phy configuration and status registers with single-cycle reads and a scratch register
`default_nettype none

module phy_csr
	import phy_csr_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  csr_req_t    csr_req,
	output csr_rsp_t    csr_rsp,
	input  logic        pll_locked,
	input  cal_status_t cal_status
);

	// fixed pattern so software can find the block
	localparam logic [`PHY_CSR_DATA_WIDTH-1:0] SIGNATURE_VALUE = 32'hdeadbeef;

	// request captured one edge after the master drives it
	csr_req_t req_q;

	// response register, drives the bus directly
	csr_rsp_t rsp_q;

	// pll lock synchronizer, the oldest sample sits in the top bit
	logic [`PHY_CSR_SYNC_STAGES-1:0] pll_sync;

	// per-cycle snapshot of everything the status registers report
	cal_status_t status_snap;
	logic        pll_snap;

	// the only writable register
	logic [`PHY_CSR_DATA_WIDTH-1:0] scratch;

	// decoded data for the captured address
	logic [`PHY_CSR_DATA_WIDTH-1:0] read_data;

	// capture stage
	// reads and writes are both handled one edge after this, so every access costs one cycle
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			req_q <= '0;
		end else begin
			req_q <= csr_req;
		end
	end

	// pll_locked comes from another clock, so it goes through a plain flop chain
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pll_sync <= '0;
		end else begin
			pll_sync <= {pll_sync[`PHY_CSR_SYNC_STAGES-2:0], pll_locked};
		end
	end

	// snapshot of the status sources, refreshed every edge
	// a read decoded at edge n therefore sees the sources as they were before edge n-1
	always_ff @(posedge clk) begin
		status_snap <= cal_status;
		pll_snap    <= pll_sync[`PHY_CSR_SYNC_STAGES-1];
	end

	// read decode
	// scratch is read directly so a write is visible to a read captured on the next edge
	always_comb begin
		read_data = '0;
		case (req_q.addr)
			SIGNATURE: begin
				read_data = SIGNATURE_VALUE;
			end
			VERSION: begin
				read_data = {`PHY_CSR_IP_VERSION, 16'h0004};
			end
			STATUS: begin
				read_data[24] = status_snap.success;
				read_data[25] = status_snap.fail;
				read_data[26] = pll_snap;
			end
			FOM: begin
				read_data[7:0]   = status_snap.fom_in;
				read_data[23:16] = status_snap.fom_out;
			end
			FAIL_INFO: begin
				read_data[7:0]   = status_snap.fail_stage;
				read_data[15:8]  = status_snap.fail_substage;
				read_data[23:16] = status_snap.fail_group;
			end
			SCRATCH: begin
				read_data = scratch;
			end
			MR3: begin
				read_data[3:0] = `PHY_CSR_MR3_DS;
			end
			default: begin
				read_data = '0;
			end
		endcase
	end

	// response stage
	// waitrequest only covers the first cycle out of reset, there is no back-pressure
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rsp_q.waitrequest <= 1'b1;
			rsp_q.rdata_valid <= 1'b0;
			rsp_q.rdata       <= '0;
		end else begin
			rsp_q.waitrequest <= 1'b0;
			rsp_q.rdata_valid <= req_q.read;
			// data is zeroed between reads so the bus never shows stale values
			if (req_q.read) begin
				rsp_q.rdata <= read_data;
			end else begin
				rsp_q.rdata <= '0;
			end
		end
	end

	// write path
	// only scratch takes writes, each byte lane follows its own enable
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			scratch <= '0;
		end else if (req_q.write && (req_q.addr == SCRATCH)) begin
			for (int i = 0; i < `PHY_CSR_BE_WIDTH; i++) begin
				if (req_q.be[i]) begin
					scratch[i*8 +: 8] <= req_q.wdata[i*8 +: 8];
				end
			end
		end
	end

	assign csr_rsp = rsp_q;

endmodule

`default_nettype wire

//--- source/phy_cal_status_top.sv
// phy calibration status top joining the result tracker to the csr register block
`default_nettype none

module phy_cal_status_top
	import phy_csr_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  csr_req_t  csr_req,
	output csr_rsp_t  csr_rsp,
	input  logic      pll_locked,
	input  logic      cal_start,
	input  logic      cal_end,
	input  logic      step_valid,
	input  cal_step_t step
);

	// calibration record from the tracker, sampled by the csr block each cycle
	cal_status_t cal_status;

	// tracker turns the step strobes into figures of merit and first-failure info
	cal_result_tracker u_tracker (
		.clk        (clk),
		.reset_n    (reset_n),
		.cal_start  (cal_start),
		.cal_end    (cal_end),
		.step_valid (step_valid),
		.step       (step),
		.cal_status (cal_status)
	);

	// csr block owns the bus and the pll lock synchronizer
	phy_csr u_csr (
		.clk        (clk),
		.reset_n    (reset_n),
		.csr_req    (csr_req),
		.csr_rsp    (csr_rsp),
		.pll_locked (pll_locked),
		.cal_status (cal_status)
	);

endmodule

`default_nettype wire

//--- dv/phy_csr_checker.sv
// protocol checker for the phy csr bus, bound into the csr register block
`default_nettype none

module phy_csr_checker (
	input logic        clk,
	input logic        reset_n,
	input logic        req_read,
	input logic        rdata_valid,
	input logic        waitrequest,
	input logic [31:0] rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	// running total of failed protocol assertions
	int assert_failures = 0;

	// high from the first edge after reset release onward
	logic out_of_reset;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			out_of_reset <= 1'b0;
		end else begin
			out_of_reset <= 1'b1;
		end
	end

	// a captured read is answered on the very next cycle
	read_answered: assert property (@(posedge clk) disable iff (!reset_n)
		req_read |=> rdata_valid)
	else begin
		$error("captured read was not answered one cycle later");
		assert_failures++;
	end

	// valid data only ever follows a captured read
	no_spurious_valid: assert property (@(posedge clk) disable iff (!reset_n)
		!req_read |=> !rdata_valid)
	else begin
		$error("rdata_valid rose without a captured read");
		assert_failures++;
	end

	// waitrequest stays low once the first edge out of reset has passed
	wait_low: assert property (@(posedge clk) disable iff (!reset_n)
		out_of_reset |-> !waitrequest)
	else begin
		$error("waitrequest high after the first edge out of reset");
		assert_failures++;
	end

	// the data bus is quiet between reads
	rdata_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		!rdata_valid |-> (rdata == 32'h0))
	else begin
		$error("rdata nonzero while rdata_valid is low");
		assert_failures++;
	end

endmodule

`default_nettype wire

//--- dv/phy_csr_tb.sv
// testbench for the phy calibration status top, driven from a table with a reference model
`default_nettype none

module phy_csr_tb
	import phy_csr_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {OP_STEP, OP_START, OP_END, OP_PLL, OP_READ, OP_WRITE} op_e;

	// one table row, data carries write data, a packed step or the pll level
	typedef struct packed {
		logic [2:0]  test;
		op_e         op;
		logic [7:0]  addr;
		logic [3:0]  be;
		logic [31:0] data;
		logic [31:0] expected;
	} entry_t;

	logic      clk;
	logic      reset_n;
	csr_req_t  csr_req;
	csr_rsp_t  csr_rsp;
	logic      pll_locked;
	logic      cal_start;
	logic      cal_end;
	logic      step_valid;
	cal_step_t step;

	entry_t      table_q[$];
	logic [31:0] burst_data[$];
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_base = 0;

	// reference model of the calibration record, scratch and synchronized lock
	cal_status_t m_status;
	logic [31:0] m_scratch;
	logic        m_pll;

	phy_cal_status_top uut (
		.clk        (clk),
		.reset_n    (reset_n),
		.csr_req    (csr_req),
		.csr_rsp    (csr_rsp),
		.pll_locked (pll_locked),
		.cal_start  (cal_start),
		.cal_end    (cal_end),
		.step_valid (step_valid),
		.step       (step)
	);

	bind phy_csr phy_csr_checker u_checker (
		.clk         (clk),
		.reset_n     (reset_n),
		.req_read    (req_q.read),
		.rdata_valid (csr_rsp.rdata_valid),
		.waitrequest (csr_rsp.waitrequest),
		.rdata       (csr_rsp.rdata)
	);

	always #50 clk = ~clk;

	// inputs always change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] make_step(input logic [7:0] stage, input logic [7:0] substage,
		input logic [7:0] group, input logic pass, input logic out);
		cal_step_t s;
		s.stage    = stage;
		s.substage = substage;
		s.group    = group;
		s.pass     = pass;
		s.out      = out;
		return {6'h0, s};
	endfunction

	// register map as the model expects to read it back
	function automatic logic [31:0] expect_read(input logic [7:0] addr);
		logic [31:0] v;
		case (addr)
			SIGNATURE: v = 32'hdeadbeef;
			VERSION:   v = 32'h00d30004;
			STATUS:    v = {5'h0, m_pll, m_status.fail, m_status.success, 24'h0};
			FOM:       v = {8'h0, m_status.fom_out, 8'h0, m_status.fom_in};
			FAIL_INFO: v = {8'h0, m_status.fail_group, m_status.fail_substage, m_status.fail_stage};
			SCRATCH:   v = m_scratch;
			MR3:       v = 32'h0;
			default:   v = 32'h0;
		endcase
		return v;
	endfunction

	// advances the model by one operation and appends the row with its expected read value
	task automatic add_entry(input logic [2:0] test, input op_e op, input logic [7:0] addr,
		input logic [3:0] be, input logic [31:0] data);
		entry_t    e;
		cal_step_t s;
		s = data[25:0];
		case (op)
			OP_STEP: begin
				if (s.pass && s.out && m_status.fom_out != 8'hff) begin
					m_status.fom_out = m_status.fom_out + 8'd1;
				end else if (s.pass && !s.out && m_status.fom_in != 8'hff) begin
					m_status.fom_in = m_status.fom_in + 8'd1;
				end else if (!s.pass && !m_status.fail) begin
					m_status.fail          = 1'b1;
					m_status.fail_stage    = s.stage;
					m_status.fail_substage = s.substage;
					m_status.fail_group    = s.group;
				end
			end
			OP_START: m_status = '0;
			OP_END:   m_status.success = m_status.success | !m_status.fail;
			OP_PLL:   m_pll = data[0];
			OP_WRITE: begin
				for (int i = 0; i < 4; i++) begin
					if (addr == SCRATCH && be[i]) begin
						m_scratch[i*8 +: 8] = data[i*8 +: 8];
					end
				end
			end
			default: ;
		endcase
		e.test     = test;
		e.op       = op;
		e.addr     = addr;
		e.be       = be;
		e.data     = data;
		// a pll row polls STATUS, so it expects the STATUS word
		e.expected = expect_read((op == OP_PLL) ? STATUS : addr);
		table_q.push_back(e);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// one read, then wait for rdata_valid with a 10 cycle limit
	task automatic read_word(input logic [7:0] addr, output logic [31:0] data, output logic ok);
		int n;
		csr_req.addr = addr;
		csr_req.read = 1'b1;
		next_cycle();
		csr_req.read = 1'b0;
		ok = 1'b0;
		data = 32'h0;
		n = 0;
		while (!ok && n < 10) begin
			next_cycle();
			if (csr_rsp.rdata_valid) begin
				ok = 1'b1;
				data = csr_rsp.rdata;
			end
			n++;
		end
		assert (ok) else begin
			$display("no read data came back from address %h within 10 cycles", addr);
			errors++;
		end
	endtask

	task automatic apply_entry(input entry_t e);
		logic [31:0] got;
		logic        ok;
		logic        done;
		int          n;
		case (e.op)
			OP_STEP: begin
				step = e.data[25:0];
				step_valid = 1'b1;
				next_cycle();
				step_valid = 1'b0;
			end
			OP_START: begin
				cal_start = 1'b1;
				next_cycle();
				cal_start = 1'b0;
			end
			OP_END: begin
				cal_end = 1'b1;
				next_cycle();
				cal_end = 1'b0;
			end
			OP_WRITE: begin
				csr_req.addr  = e.addr;
				csr_req.be    = e.be;
				csr_req.wdata = e.data;
				csr_req.write = 1'b1;
				next_cycle();
				csr_req.write = 1'b0;
			end
			OP_READ: begin
				read_word(e.addr, got, ok);
				check_value("csr_rsp.rdata", got, e.expected);
			end
			default: begin
				// lock passes a synchronizer and a snapshot, so STATUS is polled
				pll_locked = e.data[0];
				n = 0;
				done = 1'b0;
				got = 32'h0;
				while (!done && n < 10) begin
					read_word(STATUS, got, ok);
					done = ok && (got[26] == e.data[0]);
					n++;
				end
				assert (done) else begin
					$display("pll lock level %0d never showed up in STATUS", e.data[0]);
					errors++;
				end
				check_value("csr_rsp.rdata", got, e.expected);
			end
		endcase
	endtask

	// three reads on consecutive cycles must come back on consecutive valid cycles
	task automatic burst_read();
		logic [7:0] addrs [3];
		logic       gap;
		int         n;
		addrs = '{SIGNATURE, SCRATCH, VERSION};
		burst_data.delete();
		gap = 1'b0;
		n = 0;
		csr_req.read = 1'b1;
		while (burst_data.size() < 3 && n < 12) begin
			if (n < 3) begin
				csr_req.addr = addrs[n];
			end else begin
				csr_req.read = 1'b0;
			end
			next_cycle();
			if (csr_rsp.rdata_valid) begin
				burst_data.push_back(csr_rsp.rdata);
			end else if (burst_data.size() > 0) begin
				gap = 1'b1;
			end
			n++;
		end
		csr_req.read = 1'b0;
		assert (burst_data.size() == 3 && !gap) else begin
			$display("burst reads did not return as three consecutive valid cycles");
			errors++;
		end
		for (int i = 0; i < burst_data.size() && i < 3; i++) begin
			check_value("csr_rsp.rdata", burst_data[i], expect_read(addrs[i]));
		end
	endtask

	task automatic finish_test(input logic [2:0] test);
		int failed_checks;
		failed_checks = errors - test_base;
		tests_run++;
		if (failed_checks == 0) begin
			$display("test %0d passed", test);
		end else begin
			$display("test %0d failed with %0d errors", test, failed_checks);
			tests_failed++;
		end
		test_base = errors;
	endtask

	initial begin
		logic [19:0] be_pats;
		logic [2:0]  cur_test;
		int          n;
		clk        = 1'b0;
		reset_n    = 1'b0;
		csr_req    = '0;
		pll_locked = 1'b0;
		cal_start  = 1'b0;
		cal_end    = 1'b0;
		step_valid = 1'b0;
		step       = '0;
		m_status   = '0;
		m_scratch  = 32'h0;
		m_pll      = 1'b0;
		void'($urandom(32'hc418473e));

		// fixed registers and an unmapped address
		add_entry(3'd1, OP_READ, SIGNATURE, 4'h0, 32'h0);
		add_entry(3'd1, OP_READ, VERSION, 4'h0, 32'h0);
		add_entry(3'd1, OP_READ, MR3, 4'h0, 32'h0);
		add_entry(3'd1, OP_READ, 8'h03, 4'h0, 32'h0);
		add_entry(3'd1, OP_READ, 8'hff, 4'h0, 32'h0);

		// scratch merges with byte enables f, 5, a, 6 and 0 in that order
		be_pats = {4'h0, 4'h6, 4'ha, 4'h5, 4'hf};
		for (int i = 0; i < 5; i++) begin
			add_entry(3'd2, OP_WRITE, SCRATCH, be_pats[i*4 +: 4], $urandom());
			add_entry(3'd2, OP_READ, SCRATCH, 4'h0, 32'h0);
		end
		add_entry(3'd2, OP_WRITE, VERSION, 4'hf, $urandom());
		add_entry(3'd2, OP_READ, VERSION, 4'h0, 32'h0);

		// clean run with five read capture and three write leveling passes
		add_entry(3'd3, OP_START, 8'h0, 4'h0, 32'h0);
		for (int i = 0; i < 5; i++) begin
			add_entry(3'd3, OP_STEP, 8'h0, 4'h0, make_step(8'(i), 8'h1, 8'h0, 1'b1, 1'b0));
		end
		for (int i = 0; i < 3; i++) begin
			add_entry(3'd3, OP_STEP, 8'h0, 4'h0, make_step(8'(i), 8'h2, 8'h1, 1'b1, 1'b1));
		end
		add_entry(3'd3, OP_END, 8'h0, 4'h0, 32'h0);
		add_entry(3'd3, OP_READ, STATUS, 4'h0, 32'h0);
		add_entry(3'd3, OP_READ, FOM, 4'h0, 32'h0);

		// failing run keeps the first failure, then a restart clears the record
		add_entry(3'd4, OP_START, 8'h0, 4'h0, 32'h0);
		add_entry(3'd4, OP_STEP, 8'h0, 4'h0, make_step(8'h1, 8'h0, 8'h0, 1'b1, 1'b0));
		add_entry(3'd4, OP_STEP, 8'h0, 4'h0, make_step(8'h3, 8'h7, 8'h2, 1'b0, 1'b0));
		add_entry(3'd4, OP_STEP, 8'h0, 4'h0, make_step(8'h4, 8'h0, 8'h1, 1'b1, 1'b1));
		add_entry(3'd4, OP_STEP, 8'h0, 4'h0, make_step(8'h5, 8'h1, 8'h4, 1'b0, 1'b1));
		add_entry(3'd4, OP_STEP, 8'h0, 4'h0, make_step(8'h6, 8'h2, 8'h0, 1'b1, 1'b0));
		add_entry(3'd4, OP_END, 8'h0, 4'h0, 32'h0);
		add_entry(3'd4, OP_READ, STATUS, 4'h0, 32'h0);
		add_entry(3'd4, OP_READ, FAIL_INFO, 4'h0, 32'h0);
		add_entry(3'd4, OP_READ, FOM, 4'h0, 32'h0);
		add_entry(3'd4, OP_START, 8'h0, 4'h0, 32'h0);
		add_entry(3'd4, OP_READ, STATUS, 4'h0, 32'h0);
		add_entry(3'd4, OP_READ, FOM, 4'h0, 32'h0);
		add_entry(3'd4, OP_READ, FAIL_INFO, 4'h0, 32'h0);

		// lock rises then falls
		add_entry(3'd5, OP_PLL, 8'h0, 4'h0, 32'h1);
		add_entry(3'd5, OP_PLL, 8'h0, 4'h0, 32'h0);

		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;

		// waitrequest must drop once reset is released
		n = 0;
		while (csr_rsp.waitrequest && n < 10) begin
			next_cycle();
			n++;
		end
		assert (!csr_rsp.waitrequest) else begin
			$display("waitrequest stayed high after reset was released");
			errors++;
		end

		cur_test = 3'd1;
		foreach (table_q[i]) begin
			if (table_q[i].test != cur_test) begin
				finish_test(cur_test);
				cur_test = table_q[i].test;
			end
			apply_entry(table_q[i]);
		end
		finish_test(cur_test);

		burst_read();
		finish_test(3'd6);

		assert (uut.u_csr.u_checker.assert_failures == 0) else begin
			$display("protocol checker saw %0d assertion failures",
				uut.u_csr.u_checker.assert_failures);
			errors++;
		end

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
source/phy_csr_pkg.sv
source/cal_result_tracker.sv
source/phy_csr.sv
source/phy_cal_status_top.sv
dv/phy_csr_checker.sv
dv/phy_csr_tb.sv

//--- Makefile
TOP = phy_csr_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

# build the testbench, run it and look for the pass message in the log
run:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module $(TOP) -o $(TOP) --Mdir obj_dir
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall -f list.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
